// ==== axi_mem_golden.txt ====
# W addr len size burst, then len+1 lines of data strb (hex)
# R addr len size burst, then len+1 lines of expected read data (hex)
W 00000000 07 2 1
a0a1a2a3 f
b0b1b2b3 f
c0c1c2c3 f
d0d1d2d3 f
e0e1e2e3 f
f0f1f2f3 f
01234567 f
89abcdef f
R 00000000 07 2 1
a0a1a2a3
b0b1b2b3
c0c1c2c3
d0d1d2d3
e0e1e2e3
f0f1f2f3
01234567
89abcdef
W 00000028 03 2 2
10000002 f
10000003 f
10000000 f
10000001 f
W 00000030 02 2 0
11111111 7
22222222 e
33333333 9
W 00000034 02 2 1
76543210 f
fedcba98 f
0f1e2d3c f
W 00000037 01 1 1
12345678 c
9abcdef0 3
R 00000000 0f 2 1
a0a1a2a3
b0b1b2b3
c0c1c2c3
d0d1d2d3
e0e1e2e3
f0f1f2f3
01234567
89abcdef
10000000
10000001
10000002
10000003
33222233
12343210
fedcdef0
0f1e2d3c

// ==== axi_mem_pkg.sv ====
/*
 * AXI memory slave shared definitions
 * Bus widths, burst encoding and the packed channel payloads
 */
package axi_mem_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;    // One strobe per byte lane

    // AxBURST encoding
    typedef enum logic [1:0] {
        BURST_FIXED = 2'd0,
        BURST_INCR  = 2'd1,
        BURST_WRAP  = 2'd2,
        BURST_RSVD  = 2'd3                 // Stepped like FIXED
    } burst_e;

    // AW / AR request
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;            // Beats minus one
        logic [2:0]        size;           // Log2 of bytes per beat
        burst_e            burst;
    } axi_ax_t;

    // Write beat
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } axi_w_t;

    // Read beat
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } axi_r_t;

endpackage

// ==== axi_mem_slave.sv ====
/*
 * AXI4 memory slave top
 * Independent write and read controllers around a set of byte lane memories
 */
`timescale 1ns/10ps

module axi_mem_slave #(
    parameter int MEM_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 rst,
    input  axi_mem_pkg::axi_ax_t aw,
    input  logic                 aw_valid,
    output logic                 aw_ready,
    input  axi_mem_pkg::axi_w_t  w,
    input  logic                 w_valid,
    output logic                 w_ready,
    output logic                 b_valid,
    input  logic                 b_ready,
    input  axi_mem_pkg::axi_ax_t ar,
    input  logic                 ar_valid,
    output logic                 ar_ready,
    output axi_mem_pkg::axi_r_t  r,
    output logic                 r_valid,
    input  logic                 r_ready
);
    import axi_mem_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [STRB_W-1:0] lane_we;
    logic [IDX_W-1:0]  wr_index;
    logic [DATA_W-1:0] wr_data;
    logic [IDX_W-1:0]  rd_index;
    logic [DATA_W-1:0] rd_word;    // Bytes joined from all lanes

    axi_write_ctrl #(.MEM_WORDS(MEM_WORDS)) u_write_ctrl (
        .clk      (clk),
        .rst      (rst),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .lane_we  (lane_we),
        .wr_index (wr_index),
        .wr_data  (wr_data)
    );

    axi_read_ctrl #(.MEM_WORDS(MEM_WORDS)) u_read_ctrl (
        .clk      (clk),
        .rst      (rst),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .rd_index (rd_index),
        .rd_word  (rd_word)
    );

    for (genvar i = 0; i < STRB_W; i++) begin : g_lane
        mem_byte_lane #(.MEM_WORDS(MEM_WORDS)) u_lane (
            .clk      (clk),
            .we       (lane_we[i]),
            .wr_index (wr_index),
            .wr_byte  (wr_data[8*i +: 8]),
            .rd_index (rd_index),
            .rd_byte  (rd_word[8*i +: 8])
        );
    end

endmodule

// ==== axi_read_ctrl.sv ====
/*
 * AXI read channel controller
 * Takes AR, fetches each beat from the byte lanes and holds it on R
 */
`timescale 1ns/10ps

module axi_read_ctrl #(
    parameter int MEM_WORDS = 256
) (
    input  logic                           clk,
    input  logic                           rst,
    input  axi_mem_pkg::axi_ax_t           ar,
    input  logic                           ar_valid,
    output logic                           ar_ready,
    output axi_mem_pkg::axi_r_t            r,
    output logic                           r_valid,
    input  logic                           r_ready,
    output logic [$clog2(MEM_WORDS)-1:0]   rd_index,
    input  logic [axi_mem_pkg::DATA_W-1:0] rd_word
);
    import axi_mem_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int OFS_W = $clog2(STRB_W);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_FETCH,
        RD_PRESENT
    } rd_state_e;

    rd_state_e         state;
    logic              lane_wait;      // Second fetch cycle, lane data ready
    logic [7:0]        beat_cnt;
    logic [7:0]        len_q;
    logic              ar_fire;
    logic              r_fire;
    logic [ADDR_W-1:0] cur_addr;
    axi_r_t            beat_q;

    assign ar_ready = (state == RD_IDLE);
    assign r_valid  = (state == RD_PRESENT);
    assign ar_fire  = ar_valid && ar_ready;
    assign r_fire   = r_valid && r_ready;

    burst_addr_gen u_addr_gen (
        .clk  (clk),
        .rst  (rst),
        .load (ar_fire),
        .req  (ar),
        .step (r_fire),
        .addr (cur_addr)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= RD_IDLE;
            lane_wait <= 1'b0;
            beat_cnt  <= '0;
            len_q     <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (ar_fire) begin
                        len_q     <= ar.len;
                        beat_cnt  <= '0;
                        lane_wait <= 1'b0;
                        state     <= RD_FETCH;
                    end
                end
                RD_FETCH: begin
                    lane_wait <= ~lane_wait;
                    if (lane_wait) state <= RD_PRESENT;
                end
                RD_PRESENT: begin
                    if (r_fire) begin
                        beat_cnt <= beat_cnt + 8'd1;
                        state    <= r.last ? RD_IDLE : RD_FETCH;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // Held beat, stays put under back-pressure
    always_ff @(posedge clk) begin
        if (state == RD_FETCH && lane_wait) begin
            beat_q.data <= rd_word;
            beat_q.last <= (beat_cnt == len_q);
        end
    end

    assign r        = beat_q;
    assign rd_index = cur_addr[OFS_W +: IDX_W];

endmodule

// ==== axi_write_ctrl.sv ====
/*
 * AXI write channel controller
 * Takes AW, then len+1 W beats into the byte lanes, then answers on B
 */
`timescale 1ns/10ps

module axi_write_ctrl #(
    parameter int MEM_WORDS = 256
) (
    input  logic                           clk,
    input  logic                           rst,
    input  axi_mem_pkg::axi_ax_t           aw,
    input  logic                           aw_valid,
    output logic                           aw_ready,
    input  axi_mem_pkg::axi_w_t            w,
    input  logic                           w_valid,
    output logic                           w_ready,
    output logic                           b_valid,
    input  logic                           b_ready,
    output logic [axi_mem_pkg::STRB_W-1:0] lane_we,
    output logic [$clog2(MEM_WORDS)-1:0]   wr_index,
    output logic [axi_mem_pkg::DATA_W-1:0] wr_data
);
    import axi_mem_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int OFS_W = $clog2(STRB_W);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    wr_state_e         state;
    logic [7:0]        beat_cnt;
    logic [7:0]        len_q;
    logic              aw_fire;
    logic              w_fire;
    logic [ADDR_W-1:0] cur_addr;

    assign aw_ready = (state == WR_IDLE);
    assign w_ready  = (state == WR_DATA);
    assign b_valid  = (state == WR_RESP);
    assign aw_fire  = aw_valid && aw_ready;
    assign w_fire   = w_valid && w_ready;

    burst_addr_gen u_addr_gen (
        .clk  (clk),
        .rst  (rst),
        .load (aw_fire),
        .req  (aw),
        .step (w_fire),
        .addr (cur_addr)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= WR_IDLE;
            beat_cnt <= '0;
            len_q    <= '0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (aw_fire) begin
                        len_q    <= aw.len;
                        beat_cnt <= '0;
                        state    <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (w_fire) begin
                        beat_cnt <= beat_cnt + 8'd1;
                        if (beat_cnt == len_q)
                            state <= WR_RESP;   // WLAST is not checked
                    end
                end
                WR_RESP: if (b_ready) state <= WR_IDLE;
                default: state <= WR_IDLE;
            endcase
        end
    end

    // Beat lands on the same edge it is accepted
    assign lane_we  = w_fire ? w.strb : '0;
    assign wr_index = cur_addr[OFS_W +: IDX_W];
    assign wr_data  = w.data;

endmodule

// ==== burst_addr_gen.sv ====
/*
 * Burst address generator
 * Aligns the start address and steps it per beat for FIXED, INCR and WRAP
 */
`timescale 1ns/10ps

module burst_addr_gen (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           load,
    input  axi_mem_pkg::axi_ax_t           req,
    input  logic                           step,
    output logic [axi_mem_pkg::ADDR_W-1:0] addr
);
    import axi_mem_pkg::*;

    logic [ADDR_W-1:0] req_bytes;      // Bytes per beat of the new request
    logic [ADDR_W-1:0] req_total;      // Bytes in the whole burst
    logic [ADDR_W-1:0] bytes_q;
    logic [ADDR_W-1:0] lower_q;
    logic [ADDR_W-1:0] upper_q;
    logic [ADDR_W-1:0] addr_q;
    logic [ADDR_W-1:0] addr_inc;
    burst_e            burst_q;

    assign req_bytes = ADDR_W'(1) << req.size;
    assign req_total = (ADDR_W'(req.len) + ADDR_W'(1)) << req.size;
    assign addr_inc  = addr_q + bytes_q;

    // Wrap bounds only matter for WRAP
    always_ff @(posedge clk) begin
        if (load) begin
            bytes_q <= req_bytes;
            lower_q <= req.addr & ~(req_total - ADDR_W'(1));
            upper_q <= (req.addr & ~(req_total - ADDR_W'(1))) + req_total;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_q  <= '0;
            burst_q <= BURST_FIXED;
        end else if (load) begin
            addr_q  <= req.addr & ~(req_bytes - ADDR_W'(1));
            burst_q <= req.burst;
        end else if (step) begin
            case (burst_q)
                BURST_INCR: addr_q <= addr_inc;
                BURST_WRAP: addr_q <= (addr_inc >= upper_q) ? lower_q : addr_inc;
                default:    addr_q <= addr_q;   // FIXED and reserved hold
            endcase
        end
    end

    assign addr = addr_q;

endmodule

// ==== flist.f ====
axi_mem_pkg.sv
burst_addr_gen.sv
mem_byte_lane.sv
axi_write_ctrl.sv
axi_read_ctrl.sv
axi_mem_slave.sv
tb_axi_mem_slave.sv

// ==== mem_byte_lane.sv ====
/*
 * Byte lane memory
 * One byte per word, one write port and one registered read port
 */
`timescale 1ns/10ps

module mem_byte_lane #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         we,
    input  logic [$clog2(MEM_WORDS)-1:0] wr_index,
    input  logic [7:0]                   wr_byte,
    input  logic [$clog2(MEM_WORDS)-1:0] rd_index,
    output logic [7:0]                   rd_byte
);

    logic [7:0] mem [MEM_WORDS];

    always_ff @(posedge clk) begin
        if (we)
            mem[wr_index] <= wr_byte;
    end

    // Same-edge collision returns the old byte
    always_ff @(posedge clk) begin
        rd_byte <= mem[rd_index];
    end

endmodule

// ==== tb_axi_mem_slave.sv ====
/*
 * Testbench for the AXI4 memory slave
 * Replays write and read bursts from the golden file and checks every R beat,
 * the handshake timing and the hold of R under random back-pressure
 */
`timescale 1ns/10ps

module tb_axi_mem_slave;
    import axi_mem_pkg::*;

    localparam int MEM_WORDS = 256;
    localparam int CLK_HALF  = 5;

    logic    clk;
    logic    rst;
    axi_ax_t aw;
    logic    aw_valid;
    logic    aw_ready;
    axi_w_t  w;
    logic    w_valid;
    logic    w_ready;
    logic    b_valid;
    logic    b_ready;
    axi_ax_t ar;
    logic    ar_valid;
    logic    ar_ready;
    axi_r_t  r;
    logic    r_valid;
    logic    r_ready;

    axi_ax_t           cmd_q[$];
    logic [7:0]        kind_q[$];      // "W" or "R" per command
    axi_w_t            wbeat_q[$];
    logic [DATA_W-1:0] rexp_q[$];
    int                value_errors = 0;
    int                flag_errors  = 0;
    int                other_errors = 0;
    int                total_beats  = 0;
    int                n_writes     = 0;
    int                n_read_beats = 0;
    int                b_count      = 0;
    int                r_count      = 0;
    logic              loaded       = 1'b0;
    logic              stall_seen   = 1'b0;
    axi_r_t            stall_r;
    logic [31:0]       lfsr         = 32'hef6ab192;

    axi_mem_slave #(.MEM_WORDS(MEM_WORDS)) u_dut (
        .clk      (clk),
        .rst      (rst),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready)
    );

    always #CLK_HALF clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic check_r(input string name, input axi_r_t exp, input axi_r_t got);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL t=%0t %s expected data=%h last=%b got data=%h last=%b",
                     $time, name, exp.data, exp.last, got.data, got.last);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            flag_errors++;
            $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    task automatic print_counts();
        $display("Errors: %0d value, %0d handshake, %0d other",
                 value_errors, flag_errors, other_errors);
    endtask

    task automatic load_golden();
        int                fd;
        int                code;
        logic [7:0]        kind;
        logic [31:0]       f_addr;
        logic [31:0]       f_len;
        logic [31:0]       f_size;
        logic [31:0]       f_burst;
        logic [31:0]       f_data;
        logic [31:0]       f_strb;
        logic [8*256-1:0]  skip_line;
        axi_ax_t           req;
        fd = $fopen("axi_mem_golden.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the golden stimulus file");
        end else begin
            while ($fscanf(fd, " %c", kind) == 1) begin
                if (kind == "#") begin
                    code = $fgets(skip_line, fd);   // Column description
                end else begin
                    code = $fscanf(fd, "%h %h %h %h", f_addr, f_len, f_size, f_burst);
                    if (code != 4) begin
                        other_errors++;
                        $display("A command line in the golden file could not be parsed");
                    end
                    req.addr  = f_addr;
                    req.len   = f_len[7:0];
                    req.size  = f_size[2:0];
                    req.burst = burst_e'(f_burst[1:0]);
                    cmd_q.push_back(req);
                    kind_q.push_back(kind);
                    for (int i = 0; i <= req.len; i++) begin
                        if (kind == "W") begin
                            code = $fscanf(fd, "%h %h", f_data, f_strb);
                            if (code != 2) begin
                                other_errors++;
                                $display("A write beat in the golden file could not be parsed");
                            end
                            wbeat_q.push_back({f_data, f_strb[STRB_W-1:0]});
                        end else begin
                            code = $fscanf(fd, "%h", f_data);
                            if (code != 1) begin
                                other_errors++;
                                $display("A read beat in the golden file could not be parsed");
                            end
                            rexp_q.push_back(f_data);
                        end
                    end
                    if (kind == "W")
                        n_writes++;
                end
            end
            $fclose(fd);
        end
        n_read_beats = rexp_q.size();
        total_beats  = wbeat_q.size() + rexp_q.size();
        loaded       = 1'b1;
    endtask

    task automatic do_write(input axi_ax_t req);
        int b_before;
        b_before = b_count;
        aw       = req;
        aw_valid = 1'b1;
        @(negedge clk);
        while (!aw_ready) @(negedge clk);
        @(posedge clk);
        #1;
        aw_valid = 1'b0;
        for (int i = 0; i <= req.len; i++) begin
            w       = wbeat_q.pop_front();
            w_valid = 1'b1;
            @(negedge clk);
            check_flag("w_ready", 1'b1, w_ready);   // Held high for the whole burst
            while (!w_ready) @(negedge clk);
            @(posedge clk);
            #1;
        end
        w_valid = 1'b0;
        @(negedge clk);
        check_flag("w_ready", 1'b0, w_ready);
        check_flag("b_valid", 1'b1, b_valid);       // Response right after the last beat
        wait (b_count != b_before);
        @(negedge clk);
        check_flag("aw_ready", 1'b1, aw_ready);     // Back to idle after B
        check_flag("b_valid", 1'b0, b_valid);
        @(posedge clk);
        #1;
    endtask

    task automatic do_read(input axi_ax_t req);
        axi_r_t exp;
        ar       = req;
        ar_valid = 1'b1;
        @(negedge clk);
        while (!ar_ready) @(negedge clk);
        @(posedge clk);
        #1;
        ar_valid = 1'b0;
        for (int i = 0; i <= req.len; i++) begin
            repeat (2) begin
                @(negedge clk);
                check_flag("r_valid", 1'b0, r_valid);
            end
            @(negedge clk);
            check_flag("r_valid", 1'b1, r_valid);   // Two cycles after AR or R
            while (!(r_valid && r_ready)) @(negedge clk);
            exp.data = rexp_q.pop_front();
            exp.last = (i == req.len);
            check_r("r", exp, r);
        end
        @(negedge clk);
        check_flag("ar_ready", 1'b1, ar_ready);
        @(posedge clk);
        #1;
    endtask

    // Random ready for R and B with one LFSR step per bit
    always @(posedge clk) begin
        #1;
        lfsr    = lfsr_next(lfsr);
        r_ready = lfsr[0];
        lfsr    = lfsr_next(lfsr);
        b_ready = lfsr[0];
    end

    // R hold under stall and transfer counting
    always @(negedge clk) begin
        if (!rst) begin
            if (stall_seen) begin
                check_flag("r_valid", 1'b1, r_valid);
                check_r("r under stall", stall_r, r);
            end
            if (b_valid && b_ready)
                b_count++;
            if (r_valid && r_ready)
                r_count++;
        end
        stall_seen = !rst && r_valid && !r_ready;
        stall_r    = r;
    end

    initial begin : watchdog
        wait (loaded);
        repeat (total_beats * 40 + 200) @(posedge clk);
        $display("Timeout: the DUT stopped answering before all bursts finished");
        print_counts();
        $display("Verification failed");
        $finish;
    end

    initial begin : main
        clk      = 1'b0;
        rst      = 1'b1;
        aw       = '0;
        aw_valid = 1'b0;
        w        = '0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        ar       = '0;
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        load_golden();
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_flag("aw_ready", 1'b1, aw_ready);
        check_flag("ar_ready", 1'b1, ar_ready);
        check_flag("w_ready", 1'b0, w_ready);
        check_flag("b_valid", 1'b0, b_valid);
        check_flag("r_valid", 1'b0, r_valid);
        @(posedge clk);
        #1;
        foreach (cmd_q[i]) begin
            if (kind_q[i] == "W")
                do_write(cmd_q[i]);
            else
                do_read(cmd_q[i]);
        end
        repeat (4) @(negedge clk);
        if (b_count != n_writes) begin
            other_errors++;
            $display("Saw %0d write responses for %0d write bursts", b_count, n_writes);
        end
        if (r_count != n_read_beats) begin
            other_errors++;
            $display("Saw %0d read beats where %0d were expected", r_count, n_read_beats);
        end
        print_counts();
        if (value_errors + flag_errors + other_errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule
